// File: Bender.yml
package:
  name: lsu

sources:
  - verilog/lsu_pkg.sv
  - verilog/lsu_fsm.sv
  - verilog/wait_timer.sv
  - verilog/store_align.sv
  - verilog/load_align.sv
  - verilog/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_checker.sv
      - bench/lsu_tb.sv

// File: bench/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     waitrequest,
    input logic     done,
    input logic     busy,
    input bus_cmd_t bus
);

    // A timeout may drop the command
    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        ((bus.read || bus.write) && waitrequest) |=>
            ($stable(bus) || !(bus.read || bus.write)))
        else $error("bus command changed while stalled");

    a_rd_wr: assert property (@(posedge clk) disable iff (reset)
        !(bus.read && bus.write))
        else $error("read and write high together");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done longer than one cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy)
        else $error("busy high in done cycle");

endmodule

bind lsu_top lsu_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .waitrequest(waitrequest),
    .done       (done),
    .busy       (busy),
    .bus        (bus)
);

`default_nettype wire

// File: bench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 8;
    localparam int N_REQ          = 400;
    localparam int CYCLE_LIMIT    = N_REQ * 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        req;
    lsu_req_t    req_data;
    logic [31:0] readdata;
    logic        waitrequest = 1'b0;
    logic        busy;
    logic        done;
    logic [31:0] rdata;
    logic        addr_error;
    logic        bus_error;
    bus_cmd_t    bus;

    logic [31:0] mem [16];    // Bus side memory
    logic [31:0] shadow [16]; // Reference copy
    logic [31:0] rng = 32'h20bb;
    int          stall_len = 0;
    int          stall_left = 0;
    logic        cmd_seen = 1'b0;
    int          cycles = 0;
    int          accepts = 0;
    int          dones = 0;
    bus_cmd_t    acc_cmd;

    lsu_op_e op_list [12] = '{OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
                              OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};

    lsu_top #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_data   (req_data),
        .readdata   (readdata),
        .waitrequest(waitrequest),
        .busy       (busy),
        .done       (done),
        .rdata      (rdata),
        .addr_error (addr_error),
        .bus_error  (bus_error),
        .bus        (bus)
    );

    always #50 clk = ~clk;

    assign readdata = mem[bus.address[5:2]];

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: requests still running after %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // Each new command is stalled for stall_len cycles
    always @(negedge clk) begin
        if (bus.read || bus.write) begin
            if (!cmd_seen)
                stall_left = stall_len;
            cmd_seen    = 1'b1;
            waitrequest = (stall_left != 0);
            if (stall_left != 0)
                stall_left = stall_left - 1;
        end else begin
            cmd_seen    = 1'b0;
            waitrequest = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!reset && done)
            dones <= dones + 1;
        if ((bus.read || bus.write) && !waitrequest) begin
            accepts <= accepts + 1;
            acc_cmd <= bus;
            for (int i = 0; i < 4; i++) begin
                if (bus.write && bus.byteenable[i])
                    mem[bus.address[5:2]][31 - 8 * i -: 8] <= bus.writedata[31 - 8 * i -: 8];
            end
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int rand_below(int n);
        return int'(rand_word() % n);
    endfunction

    function automatic logic expected_legal(lsu_op_e op, int k);
        case (op)
            OP_LH, OP_LHU, OP_SH: return (k % 2) == 0;
            OP_LW, OP_SW:         return k == 0;
            default:              return 1'b1;
        endcase
    endfunction

    function automatic logic [3:0] expected_be(lsu_op_e op, int k);
        logic [3:0] be;
        be = '0;
        for (int i = 0; i < 4; i++) begin
            case (op)
                OP_LB, OP_LBU, OP_SB: be[i] = (i == k);
                OP_LH, OP_LHU, OP_SH: be[i] = (i / 2 == k / 2);
                OP_LWL, OP_SWL:       be[i] = (i >= k);
                OP_LWR, OP_SWR:       be[i] = (i <= k);
                default:              be[i] = 1'b1;
            endcase
        end
        return be;
    endfunction

    // Lane i takes rt byte j counted from the MSB
    function automatic logic [31:0] store_lanes(lsu_op_e op, int k, logic [31:0] rt);
        logic [31:0] wd;
        logic [3:0]  be;
        int          j;
        wd = '0;
        be = expected_be(op, k);
        for (int i = 0; i < 4; i++) begin
            case (op)
                OP_SB:   j = i - k + 3;
                OP_SH:   j = i - k + 2;
                OP_SWL:  j = i - k;
                OP_SWR:  j = i + 3 - k;
                default: j = i;
            endcase
            if (be[i])
                wd[31 - 8 * i -: 8] = rt[31 - 8 * j -: 8];
        end
        return wd;
    endfunction

    function automatic logic [31:0] load_result(lsu_op_e op, int k, logic [31:0] m,
                                                logic [31:0] rt);
        logic [31:0] r;
        logic [7:0]  b;
        logic [15:0] h;
        b = m[31 - 8 * k -: 8];
        h = m[31 - 8 * (k & 2) -: 16];
        r = rt;
        case (op)
            OP_LB:  r = {{24{b[7]}}, b};
            OP_LBU: r = {24'd0, b};
            OP_LH:  r = {{16{h[15]}}, h};
            OP_LHU: r = {16'd0, h};
            OP_LWL: begin
                for (int j = 0; j <= 3 - k; j++)
                    r[31 - 8 * j -: 8] = m[31 - 8 * (k + j) -: 8];
            end
            OP_LWR: begin
                for (int j = 3 - k; j < 4; j++)
                    r[31 - 8 * j -: 8] = m[31 - 8 * (j + k - 3) -: 8];
            end
            default: r = m;
        endcase
        return r;
    endfunction

    task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic run_request();
        lsu_req_t    r;
        int          k;
        int          w;
        int          n;
        int          s;
        int          lat;
        int          acc0;
        logic        legal;
        logic        to;
        logic        ld;
        logic [3:0]  be;
        logic [31:0] wd;
        logic [31:0] rdata0;

        r.op = op_list[rand_below(12)];
        w    = rand_below(16);
        k    = rand_below(4);
        if (r.op inside {OP_LH, OP_LHU, OP_SH} && rand_below(4) != 0)
            k = k & 2; // Mostly aligned
        if (r.op inside {OP_LW, OP_SW} && rand_below(4) != 0)
            k = 0;
        r.addr      = rand_word();
        r.addr[5:0] = {w[3:0], k[1:0]};
        r.rt        = rand_word();
        n           = rand_below(16);
        s           = (n < 12) ? n % 4 : (n < 14 ? TIMEOUT_CYCLES - 1 : TIMEOUT_CYCLES + n - 14);

        legal  = expected_legal(r.op, k);
        to     = legal && (s >= TIMEOUT_CYCLES);
        ld     = r.op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
        be     = expected_be(r.op, k);
        acc0   = accepts;
        rdata0 = '0;
        stall_len = s;

        @(negedge clk);
        req      = 1'b1;
        req_data = r;
        lat      = 0;
        do begin
            @(negedge clk);
            lat = lat + 1;
            if (lat == 1) begin
                check_equal("busy", busy, legal);
                rdata0 = rdata;
            end
            req = !done && busy && (rand_below(4) == 0); // Must be ignored
            req_data.addr = rand_word();
            req_data.rt   = rand_word();
        end while (!done);
        req = 1'b0;

        check_equal("latency", lat, !legal ? 1 : (to ? TIMEOUT_CYCLES + 1 : s + 2));
        check_equal("busy", busy, 1'b0);
        check_equal("addr_error", addr_error, !legal);
        check_equal("bus_error", bus_error, to);
        check_equal("accepted commands", accepts - acc0, (legal && !to) ? 1 : 0);
        if (legal && !to) begin
            check_equal("bus.address", acc_cmd.address, {r.addr[31:2], 2'b00});
            check_equal("bus.read", acc_cmd.read, ld);
            check_equal("bus.write", acc_cmd.write, !ld);
            check_equal("bus.byteenable", acc_cmd.byteenable, be);
            if (ld) begin
                check_equal("rdata", rdata, load_result(r.op, k, shadow[w], r.rt));
            end else begin
                wd = store_lanes(r.op, k, r.rt);
                check_equal("bus.writedata", acc_cmd.writedata, wd);
                check_equal("rdata", rdata, rdata0);
                for (int i = 0; i < 4; i++) begin
                    if (be[i])
                        shadow[w][31 - 8 * i -: 8] = wd[31 - 8 * i -: 8];
                end
            end
        end
        if (to)
            check_equal("rdata", rdata, 32'd0);
        check_equal("memory word", mem[w], shadow[w]);
    endtask

    initial begin
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i]    = {4{i[7:0]}} ^ 32'h5a3c96e1;
            shadow[i] = mem[i];
        end
        repeat (8) @(negedge clk);
        check_equal("busy", busy, 1'b0);
        check_equal("done", done, 1'b0);
        check_equal("bus.read", bus.read, 1'b0);
        check_equal("bus.write", bus.write, 1'b0);
        check_equal("addr_error", addr_error, 1'b0);
        check_equal("bus_error", bus_error, 1'b0);
        reset = 1'b0;

        for (int i = 0; i < N_REQ; i++) begin
            repeat (rand_below(4)) @(negedge clk);
            run_request();
        end
        @(negedge clk);

        check_equal("done count", dones, N_REQ);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/lsu_pkg.sv
verilog/lsu_fsm.sv
verilog/wait_timer.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

// File: verilog/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        accept,
    input  lsu_req_t    cur_req,
    input  logic [3:0]  byteenable,
    input  logic [31:0] readdata,
    output logic [31:0] rdata
);

    logic [3:0]  be_q;
    logic [31:0] data_q;
    logic        hit_q;    // Load accepted in the previous cycle
    logic        load_acc;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] result;

    assign load_acc = accept && is_load(cur_req.op);

    always_ff @(posedge clk) begin
        if (load_acc) begin
            be_q   <= byteenable;
            data_q <= readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            hit_q <= 1'b0;
        else
            hit_q <= load_acc;
    end

    always_comb begin
        byte_sel = lane_byte(data_q, 2'd0);
        for (int i = 1; i < 4; i++) begin
            if (be_q[i])
                byte_sel = lane_byte(data_q, 2'(i));
        end
        half_sel = be_q[2] ? data_q[15:0] : data_q[31:16];
    end

    always_comb begin
        result = data_q;
        case (cur_req.op)
            OP_LB:  result = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU: result = {24'd0, byte_sel};
            OP_LH:  result = {{16{half_sel[15]}}, half_sel};
            OP_LHU: result = {16'd0, half_sel};
            OP_LWL: begin
                case (be_q)
                    4'b1000: result = {data_q[7:0], cur_req.rt[23:0]};
                    4'b1100: result = {data_q[15:0], cur_req.rt[15:0]};
                    4'b1110: result = {data_q[23:0], cur_req.rt[7:0]};
                    default: result = data_q;
                endcase
            end
            OP_LWR: begin
                case (be_q)
                    4'b0001: result = {cur_req.rt[31:8], data_q[31:24]};
                    4'b0011: result = {cur_req.rt[31:16], data_q[31:16]};
                    4'b0111: result = {cur_req.rt[31:24], data_q[31:8]};
                    default: result = data_q;
                endcase
            end
            default: result = data_q; // LW
        endcase
    end

    // Zero after a timeout or a store
    assign rdata = hit_q ? result : 32'd0;

endmodule

`default_nettype wire

// File: verilog/lsu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_fsm
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  lsu_req_t req_data,
    input  logic     legal,
    input  logic     waitrequest,
    input  logic     timeout,
    output lsu_req_t cur_req,
    output logic     cmd_active,
    output logic     is_read,
    output logic     accept,
    output logic     busy,
    output logic     done,
    output logic     addr_error,
    output logic     bus_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_FINISH
    } state_e;

    state_e state;
    logic   timed_out;
    logic   take_req;

    // Only an idle unit takes a request, so done stays one cycle wide
    assign take_req = req && (state == ST_IDLE);

    assign cmd_active = (state == ST_ACCESS) && legal;
    assign is_read    = is_load(cur_req.op);
    assign accept     = cmd_active && !waitrequest;
    assign busy       = cmd_active;

    // Misaligned access finishes in its first cycle without a bus command
    assign addr_error = (state == ST_ACCESS) && !legal;
    assign bus_error  = (state == ST_FINISH) && timed_out;
    assign done       = addr_error || (state == ST_FINISH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            timed_out <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_req)
                        state <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (!legal) begin
                        state <= ST_IDLE;
                    end else if (accept || timeout) begin
                        state     <= ST_FINISH;
                        timed_out <= timeout;
                    end
                end
                default: state <= ST_IDLE; // Done cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req)
            cur_req <= req_data;
    end

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

// Lane i is byteenable bit i. Lane 0 carries data bits 31:24 (big-endian)
// and a byte address with offset k selects lane k.
package lsu_pkg;

    typedef enum logic [5:0] {
        OP_LB  = 6'b100000,
        OP_LH  = 6'b100001,
        OP_LWL = 6'b100010,
        OP_LW  = 6'b100011,
        OP_LBU = 6'b100100,
        OP_LHU = 6'b100101,
        OP_LWR = 6'b100110,
        OP_SB  = 6'b101000,
        OP_SH  = 6'b101001,
        OP_SWL = 6'b101010,
        OP_SW  = 6'b101011,
        OP_SWR = 6'b101110
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr; // Byte address
        logic [31:0] rt;   // Old rt, or store data
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] address; // Word aligned
        logic        read;
        logic        write;
        logic [3:0]  byteenable;
        logic [31:0] writedata;
    } bus_cmd_t;

    function automatic logic is_load(lsu_op_e op);
        return op[5:3] == 3'b100;
    endfunction

    // Lanes touched by an access at offset k
    function automatic logic [3:0] lane_mask(lsu_op_e op, logic [1:0] k);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 4'b0001 << k;
            OP_LH, OP_LHU, OP_SH: return k[1] ? 4'b1100 : 4'b0011;
            OP_LWL, OP_SWL:       return 4'b1111 << k;       // Lanes k..3
            OP_LWR, OP_SWR:       return 4'b1111 >> (~k);    // Lanes 0..k
            default:              return 4'b1111;
        endcase
    endfunction

    function automatic logic [7:0] lane_byte(logic [31:0] word, logic [1:0] lane);
        return word[31 - 8 * lane -: 8];
    endfunction

endpackage

`default_nettype wire

// File: verilog/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  lsu_req_t    req_data,
    input  logic [31:0] readdata,
    input  logic        waitrequest,
    output logic        busy,
    output logic        done,
    output logic [31:0] rdata,
    output logic        addr_error,
    output logic        bus_error,
    output bus_cmd_t    bus
);

    lsu_req_t    cur_req;
    logic        cmd_active;
    logic        is_read;
    logic        accept;
    logic        legal;
    logic        timeout;
    logic [3:0]  byteenable;
    logic [31:0] writedata;
    logic [31:0] word_addr;

    lsu_fsm i_fsm (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_data   (req_data),
        .legal      (legal),
        .waitrequest(waitrequest),
        .timeout    (timeout),
        .cur_req    (cur_req),
        .cmd_active (cmd_active),
        .is_read    (is_read),
        .accept     (accept),
        .busy       (busy),
        .done       (done),
        .addr_error (addr_error),
        .bus_error  (bus_error)
    );

    wait_timer #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) i_timer (
        .clk        (clk),
        .reset      (reset),
        .cmd_active (cmd_active),
        .waitrequest(waitrequest),
        .timeout    (timeout)
    );

    store_align i_store (
        .cur_req   (cur_req),
        .byteenable(byteenable),
        .writedata (writedata),
        .word_addr (word_addr),
        .legal     (legal)
    );

    load_align i_load (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .cur_req   (cur_req),
        .byteenable(byteenable),
        .readdata  (readdata),
        .rdata     (rdata)
    );

    // Fields come from the latched request, so they hold during a stall
    assign bus.address    = word_addr;
    assign bus.read       = cmd_active && is_read;
    assign bus.write      = cmd_active && !is_read;
    assign bus.byteenable = byteenable;
    assign bus.writedata  = writedata;

endmodule

`default_nettype wire

// File: verilog/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align
    import lsu_pkg::*;
(
    input  lsu_req_t    cur_req,
    output logic [3:0]  byteenable,
    output logic [31:0] writedata,
    output logic [31:0] word_addr,
    output logic        legal
);

    logic [1:0] k;
    logic [4:0] shift_k;    // 8 * k
    logic [4:0] shift_rest; // 8 * (3 - k)

    assign k          = cur_req.addr[1:0];
    assign shift_k    = {k, 3'b000};
    assign shift_rest = {~k, 3'b000};

    assign word_addr  = {cur_req.addr[31:2], 2'b00};
    assign byteenable = lane_mask(cur_req.op, k);

    always_comb begin
        case (cur_req.op)
            OP_SB:
                writedata = {cur_req.rt[7:0], 24'd0} >> shift_k;
            OP_SH:
                writedata = {cur_req.rt[15:0], 16'd0} >> shift_k;
            OP_SWL:
                writedata = cur_req.rt >> shift_k;    // High bytes into lanes k..3
            OP_SWR:
                writedata = cur_req.rt << shift_rest; // Low bytes into lanes 0..k
            OP_SW:
                writedata = cur_req.rt;
            default:
                writedata = 32'd0;
        endcase
    end

    always_comb begin
        case (cur_req.op)
            OP_LH, OP_LHU, OP_SH:
                legal = !k[0];
            OP_LW, OP_SW:
                legal = (k == 2'b00);
            default:
                legal = 1'b1; // Bytes and unaligned word ops
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module wait_timer #(
    parameter int TIMEOUT_CYCLES = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic cmd_active,
    input  logic waitrequest,
    output logic timeout
);

    localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

    logic [CW-1:0] count; // Stalled cycles before this one
    logic          stalled;

    assign stalled = cmd_active && waitrequest;

    // Current cycle is the last one allowed
    assign timeout = stalled && (count == CW'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset || !stalled)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

`default_nettype wire
